// ==== prog.hex ====
// one 32-bit instruction word per line, from word address 0 upward.
// load, two-pass loop, fence.i, forward branch, then nops.
00000093
00200113
00002183
00108093
00120213
fe209ce3
0000100f
00500293
00000463
00000013
00600313
00000013
00000013
00000013

// ==== fetch.f ====
fetch_pkg.sv
l1i_cache.sv
ifu_pc_ctrl.sv
imem_bus.sv
fetch_top.sv
fetch_sva.sv
tb_fetch.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the fetch testbench with verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -j 0 --top-module tb_fetch -f fetch.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_fetch +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $LOG"
  exit 1
fi

// ==== tb_fetch.sv ====
`timescale 1ns/1ns

module tb_fetch;
  import fetch_pkg::*;

  localparam int unsigned SEED = 32'hb681;
  // roughly 4x the worst-case refills, stall gaps and ready gaps of the trace.
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int TRACE_LEN      = 14;
  localparam int IDX_W          = $clog2(IMEM_WORDS);

  // valid_o expected in the first cycle of a pc.
  localparam int FIRST_HIT  = 1;
  localparam int FIRST_MISS = 2;

  localparam int KIND_NONE = 0;
  localparam int KIND_CTRL = 1;
  localparam int KIND_LOAD = 2;

  logic            clk;
  logic            rst;
  logic [XLEN-1:0] npc;
  logic            pc_valid;
  logic            pc_skip;
  logic            prev_valid;
  logic            next_ready;
  logic [XLEN-1:0] inst;
  logic [XLEN-1:0] pc;
  logic            valid;
  logic            ready;

  logic [XLEN-1:0] ref_mem [IMEM_WORDS];
  logic [XLEN-1:0] trace_pc [TRACE_LEN];
  int              first_exp [TRACE_LEN];

  int              check_cnt;
  int              err_cnt;
  int              cycle_cnt;
  int              k;
  int              gap;
  int              kind;
  logic            pending;
  logic            first;
  logic            redirect_now;
  logic            hold_chk;
  logic [XLEN-1:0] held_pc;
  logic [XLEN-1:0] held_inst;

  fetch_top dut0 (
    .clk          (clk),
    .rst          (rst),
    .npc_i        (npc),
    .pc_valid_i   (pc_valid),
    .pc_skip_i    (pc_skip),
    .prev_valid_i (prev_valid),
    .next_ready_i (next_ready),
    .inst_o       (inst),
    .pc_o         (pc),
    .valid_o      (valid),
    .ready_o      (ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check_word(input string name, input logic [XLEN-1:0] exp_val,
                            input logic [XLEN-1:0] act_val);
    check_cnt++;
    assert (act_val === exp_val) else begin
      err_cnt++;
      $display("Fail %s: expected %h, actual %h", name, exp_val, act_val);
    end
  endtask

  task automatic check_bit(input string name, input logic exp_val, input logic act_val);
    check_cnt++;
    assert (act_val === exp_val) else begin
      err_cnt++;
      $display("Fail %s: expected %b, actual %b", name, exp_val, act_val);
    end
  endtask

  // which resolve path the next stage answers with.
  function automatic int resolve_kind(input logic [XLEN-1:0] word);
    logic [6:0] op;
    op = word[6:0];
    if (op == OP_BRANCH || op == OP_JAL || op == OP_JALR || op == OP_SYSTEM) begin
      return KIND_CTRL;
    end
    if (op == OP_LOAD) begin
      return KIND_LOAD;
    end
    return KIND_NONE;
  endfunction

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, the fetch trace did not complete", TIMEOUT_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    rst        = 1'b1;
    npc        = '0;
    pc_valid   = 1'b0;
    pc_skip    = 1'b0;
    prev_valid = 1'b0;
    next_ready = 1'b0;
    check_cnt  = 0;
    err_cnt    = 0;
    void'($urandom(SEED));
    $readmemh("prog.hex", ref_mem);

    // load, two loop passes, fence.i, forward branch.
    trace_pc  = '{32'h00, 32'h04, 32'h08, 32'h0c, 32'h10, 32'h14, 32'h0c,
                  32'h10, 32'h14, 32'h18, 32'h1c, 32'h20, 32'h28, 32'h2c};
    first_exp = '{FIRST_MISS, FIRST_HIT, FIRST_MISS, FIRST_HIT, FIRST_MISS,
                  FIRST_HIT, FIRST_HIT, FIRST_HIT, FIRST_HIT, FIRST_MISS,
                  FIRST_MISS, FIRST_MISS, FIRST_MISS, FIRST_HIT};

    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_word("reset_pc", PC_INIT, pc);
    check_bit("reset_valid", 1'b0, valid);

    k        = 0;
    gap      = 0;
    pending  = 1'b0;
    first    = 1'b0;
    hold_chk = 1'b0;
    while (k < TRACE_LEN) begin
      @(posedge clk);
      #1;
      redirect_now = 1'b0;
      prev_valid   = 1'b0;
      pc_valid     = 1'b0;
      pc_skip      = 1'b0;
      next_ready   = ($urandom % 4) != 0;
      if (pending) begin
        if (gap > 0) begin
          gap--;
        end else begin
          redirect_now = 1'b1;
          prev_valid   = 1'b1;
          pc_valid     = (kind == KIND_CTRL);
          pc_skip      = (kind == KIND_LOAD);
          npc          = trace_pc[k];
        end
      end

      @(negedge clk);
      check_bit("ready_inverse", !valid, ready);
      if (hold_chk) begin
        check_word("hold_pc", held_pc, pc);
        check_word("hold_inst", held_inst, inst);
        check_bit("hold_valid", 1'b1, valid);
      end
      if (pending) begin
        check_bit("stall_valid", 1'b0, valid);
      end
      if (first) begin
        check_word("first_cycle_pc", trace_pc[k], pc);
        if (first_exp[k] == FIRST_HIT) begin
          check_bit("first_cycle_hit", 1'b1, valid);
        end else begin
          check_bit("first_cycle_miss", 1'b0, valid);
        end
        first = 1'b0;
      end
      hold_chk  = valid && !next_ready;
      held_pc   = pc;
      held_inst = inst;

      if (redirect_now) begin
        pending = 1'b0;
        first   = 1'b1;
      end else if (valid && next_ready) begin
        check_word("handoff_pc", trace_pc[k], pc);
        check_word("handoff_inst", ref_mem[trace_pc[k][L1I_BYTE_W +: IDX_W]], inst);
        kind = resolve_kind(ref_mem[trace_pc[k][L1I_BYTE_W +: IDX_W]]);
        k++;
        if (kind != KIND_NONE) begin
          pending = 1'b1;
          gap     = 1 + int'($urandom % 4);
        end else begin
          first = 1'b1;
        end
      end
    end

    err_cnt = err_cnt + dut0.sva0.fail_cnt;
    $display("checks run: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== fetch_sva.sv ====
`timescale 1ns/1ns

module fetch_sva (
  input logic                       clk,
  input logic                       rst,
  input logic [fetch_pkg::XLEN-1:0] pc_i,
  input logic [fetch_pkg::XLEN-1:0] inst_i,
  input logic                       valid_i,
  input logic                       ready_i,
  input logic                       next_ready_i,
  input logic                       prev_valid_i,
  input logic                       pc_valid_i,
  input logic                       pc_skip_i
);
  import fetch_pkg::*;

  logic waits_npc;
  logic stalled;
  int   fail_cnt = 0;

  assign waits_npc = inst_i[6:0] inside {OP_JAL, OP_JALR, OP_BRANCH, OP_SYSTEM, OP_LOAD};

  // stall as seen from the ports.
  always_ff @(posedge clk) begin
    if (rst) begin
      stalled <= 1'b0;
    end else if (stalled && prev_valid_i && (pc_valid_i || pc_skip_i)) begin
      stalled <= 1'b0;
    end else if (valid_i && next_ready_i && waits_npc) begin
      stalled <= 1'b1;
    end
  end

  ready_is_not_valid: assert property (@(posedge clk) disable iff (rst)
    ready_i == !valid_i)
    else begin
      fail_cnt++;
      $error("ready_o is not the inverse of valid_o");
    end

  hold_under_backpressure: assert property (@(posedge clk) disable iff (rst)
    valid_i && !next_ready_i |=> $stable(pc_i) && $stable(inst_i) && valid_i)
    else begin
      fail_cnt++;
      $error("pc_o, inst_o or valid_o changed while next_ready_i was low");
    end

  no_valid_while_stalled: assert property (@(posedge clk) disable iff (rst)
    stalled |-> !valid_i)
    else begin
      fail_cnt++;
      $error("valid_o high while the fetch stage waits for a resolved pc");
    end

endmodule

bind fetch_top fetch_sva sva0 (
  .clk          (clk),
  .rst          (rst),
  .pc_i         (pc_o),
  .inst_i       (inst_o),
  .valid_i      (valid_o),
  .ready_i      (ready_o),
  .next_ready_i (next_ready_i),
  .prev_valid_i (prev_valid_i),
  .pc_valid_i   (pc_valid_i),
  .pc_skip_i    (pc_skip_i)
);

// ==== fetch_top.sv ====
`timescale 1ns/1ns

module fetch_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [fetch_pkg::XLEN-1:0] npc_i,
  input  logic                       pc_valid_i,
  input  logic                       pc_skip_i,
  input  logic                       prev_valid_i,
  input  logic                       next_ready_i,
  output logic [fetch_pkg::XLEN-1:0] inst_o,
  output logic [fetch_pkg::XLEN-1:0] pc_o,
  output logic                       valid_o,
  output logic                       ready_o
);
  import fetch_pkg::*;

  logic [XLEN-1:0] fetch_pc;
  logic [XLEN-1:0] cache_inst;
  logic            cache_hit;
  logic            fence;

  logic [XLEN-1:0] araddr;
  logic            arvalid;
  logic [XLEN-1:0] rdata;
  logic            rvalid;

  assign pc_o = fetch_pc;

  ifu_pc_ctrl u_pc_ctrl (
    .clk          (clk),
    .rst          (rst),
    .npc_i        (npc_i),
    .pc_valid_i   (pc_valid_i),
    .pc_skip_i    (pc_skip_i),
    .prev_valid_i (prev_valid_i),
    .next_ready_i (next_ready_i),
    .inst_i       (cache_inst),
    .hit_i        (cache_hit),
    .pc_o         (fetch_pc),
    .inst_o       (inst_o),
    .valid_o      (valid_o),
    .ready_o      (ready_o),
    .fence_o      (fence)
  );

  l1i_cache u_l1i (
    .clk       (clk),
    .rst       (rst),
    .pc_i      (fetch_pc),
    .fence_i   (fence),
    .inst_o    (cache_inst),
    .hit_o     (cache_hit),
    .araddr_o  (araddr),
    .arvalid_o (arvalid),
    .rdata_i   (rdata),
    .rvalid_i  (rvalid)
  );

  imem_bus u_imem (
    .clk       (clk),
    .rst       (rst),
    .araddr_i  (araddr),
    .arvalid_i (arvalid),
    .rdata_o   (rdata),
    .rvalid_o  (rvalid)
  );

endmodule

// ==== imem_bus.sv ====
`timescale 1ns/1ns

module imem_bus (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [fetch_pkg::XLEN-1:0] araddr_i,
  input  logic                       arvalid_i,
  output logic [fetch_pkg::XLEN-1:0] rdata_o,
  output logic                       rvalid_o
);
  import fetch_pkg::*;

  logic [XLEN-1:0] mem [IMEM_WORDS];

  logic                              busy;
  logic [$clog2(IMEM_WORDS)-1:0]     rd_idx;
  logic [$clog2(IMEM_LATENCY+1)-1:0] wait_cnt;

  initial begin
    $readmemh("prog.hex", mem);
  end

  // one request at a time; strobes while busy are dropped.
  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      wait_cnt <= '0;
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= 1'b0;
      if (!busy) begin
        if (arvalid_i) begin
          busy     <= 1'b1;
          wait_cnt <= ($clog2(IMEM_LATENCY+1))'(IMEM_LATENCY - 1);
        end
      end else begin
        // last count, so rvalid lands IMEM_LATENCY cycles after the request.
        if (wait_cnt == 1) begin
          busy     <= 1'b0;
          rvalid_o <= 1'b1;
        end
        wait_cnt <= wait_cnt - 1'b1;
      end
    end
  end

  // request address and read data.
  always_ff @(posedge clk) begin
    if (!busy && arvalid_i) begin
      rd_idx <= araddr_i[L1I_BYTE_W +: $clog2(IMEM_WORDS)];
    end
    if (busy && wait_cnt == 1) begin
      rdata_o <= mem[rd_idx];
    end
  end

endmodule

// ==== ifu_pc_ctrl.sv ====
`timescale 1ns/1ns

module ifu_pc_ctrl (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [fetch_pkg::XLEN-1:0] npc_i,
  input  logic                       pc_valid_i,
  input  logic                       pc_skip_i,
  input  logic                       prev_valid_i,
  input  logic                       next_ready_i,
  input  logic [fetch_pkg::XLEN-1:0] inst_i,
  input  logic                       hit_i,
  output logic [fetch_pkg::XLEN-1:0] pc_o,
  output logic [fetch_pkg::XLEN-1:0] inst_o,
  output logic                       valid_o,
  output logic                       ready_o,
  output logic                       fence_o
);
  import fetch_pkg::*;

  logic [XLEN-1:0] pc;
  logic            stall;

  logic [6:0] opcode;
  logic       is_ctrl;
  logic       is_load;
  logic       is_fence_i;
  logic       handoff;
  logic       redirect;

  assign opcode = inst_i[6:0];

  // jumps, branches and system ops all wait for a resolved pc.
  assign is_ctrl = (opcode == OP_JAL) ||
                   (opcode == OP_JALR) ||
                   (opcode == OP_BRANCH) ||
                   (opcode == OP_SYSTEM);

  assign is_load    = (opcode == OP_LOAD);
  assign is_fence_i = (inst_i == INST_FENCE_I);

  assign valid_o = hit_i && !stall;
  assign ready_o = !valid_o;
  assign pc_o    = pc;
  assign inst_o  = inst_i;

  assign handoff = valid_o && next_ready_i;

  // branches resolve through pc_valid, loads and control through the skip path.
  assign redirect = stall && prev_valid_i &&
                    ((is_ctrl && pc_valid_i) || ((is_ctrl || is_load) && pc_skip_i));

  assign fence_o = handoff && is_fence_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc    <= PC_INIT;
      stall <= 1'b0;
    end else begin
      if (redirect) begin
        stall <= 1'b0;
        pc    <= npc_i;
      end else if (handoff) begin
        if (is_ctrl || is_load) begin
          // hold pc until the next stage supplies npc.
          stall <= 1'b1;
        end else begin
          pc <= pc + XLEN'(4);
        end
      end
    end
  end

endmodule

// ==== l1i_cache.sv ====
`timescale 1ns/1ns

module l1i_cache (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [fetch_pkg::XLEN-1:0] pc_i,
  input  logic                       fence_i,
  output logic [fetch_pkg::XLEN-1:0] inst_o,
  output logic                       hit_o,
  output logic [fetch_pkg::XLEN-1:0] araddr_o,
  output logic                       arvalid_o,
  input  logic [fetch_pkg::XLEN-1:0] rdata_i,
  input  logic                       rvalid_i
);
  import fetch_pkg::*;

  typedef enum logic [1:0] {
    RF_IDLE,
    RF_WAIT_EVEN,
    RF_REQ_ODD,
    RF_WAIT_ODD
  } refill_state_t;

  refill_state_t state;

  logic [XLEN-1:0]      data_mem [L1I_SETS][L1I_LINE_WORDS];
  logic [L1I_TAG_W-1:0] tag_mem  [L1I_SETS];
  logic [L1I_SETS-1:0]  line_valid;

  logic [L1I_TAG_W-1:0] pc_tag;
  logic [L1I_IDX_W-1:0] pc_idx;
  logic [L1I_OFF_W-1:0] pc_off;

  // line under refill, captured when the miss is seen.
  logic [L1I_TAG_W-1:0] fill_tag;
  logic [L1I_IDX_W-1:0] fill_idx;

  assign pc_tag = pc_i[XLEN-1 -: L1I_TAG_W];
  assign pc_idx = pc_i[L1I_OFF_W+L1I_BYTE_W +: L1I_IDX_W];
  assign pc_off = pc_i[L1I_BYTE_W +: L1I_OFF_W];

  assign hit_o  = line_valid[pc_idx] && (tag_mem[pc_idx] == pc_tag);
  assign inst_o = data_mem[pc_idx][pc_off];

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= RF_IDLE;
      line_valid <= '0;
      arvalid_o  <= 1'b0;
    end else begin
      arvalid_o <= 1'b0;
      case (state)
        RF_IDLE: begin
          if (!hit_o) begin
            // even word first, offset cleared.
            arvalid_o          <= 1'b1;
            line_valid[pc_idx] <= 1'b0;
            state              <= RF_WAIT_EVEN;
          end
        end
        RF_WAIT_EVEN: begin
          if (rvalid_i) begin
            state <= RF_REQ_ODD;
          end
        end
        RF_REQ_ODD: begin
          arvalid_o <= 1'b1;
          state     <= RF_WAIT_ODD;
        end
        RF_WAIT_ODD: begin
          if (rvalid_i) begin
            line_valid[fill_idx] <= 1'b1;
            state                <= RF_IDLE;
          end
        end
        default: begin
          state <= RF_IDLE;
        end
      endcase
      // fence.i drops every line.
      if (fence_i) begin
        line_valid <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      RF_IDLE: begin
        fill_tag <= pc_tag;
        fill_idx <= pc_idx;
        araddr_o <= {pc_tag, pc_idx, {L1I_OFF_W{1'b0}}, {L1I_BYTE_W{1'b0}}};
      end
      RF_WAIT_EVEN: begin
        if (rvalid_i) begin
          data_mem[fill_idx][0] <= rdata_i;
        end
      end
      RF_REQ_ODD: begin
        araddr_o <= {fill_tag, fill_idx, L1I_OFF_W'(1), {L1I_BYTE_W{1'b0}}};
      end
      RF_WAIT_ODD: begin
        if (rvalid_i) begin
          data_mem[fill_idx][1] <= rdata_i;
          tag_mem[fill_idx]     <= fill_tag;
        end
      end
      default: begin
        araddr_o <= araddr_o;
      end
    endcase
  end

endmodule

// ==== fetch_pkg.sv ====
package fetch_pkg;

  // address and instruction word width.
  localparam int XLEN = 32;

  localparam logic [XLEN-1:0] PC_INIT = 32'h0000_0000;

  // cache geometry.
  localparam int L1I_SETS       = 4;
  localparam int L1I_IDX_W      = 2;
  localparam int L1I_LINE_WORDS = 2;
  localparam int L1I_OFF_W      = 1;
  localparam int L1I_BYTE_W     = 2;
  localparam int L1I_TAG_W      = XLEN - L1I_IDX_W - L1I_OFF_W - L1I_BYTE_W;

  // base opcodes, bits [6:0] of the instruction.
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;

  // fence.i with rd, rs1 and imm all zero.
  localparam logic [XLEN-1:0] INST_FENCE_I = 32'h0000_100f;

  // instruction memory size and read latency in cycles.
  localparam int IMEM_WORDS   = 64;
  localparam int IMEM_LATENCY = 3;

endpackage
